// ==== group_interco.f ====
+incdir+verilog
verilog/group_pkg.sv
verilog/group_req_decode.sv
verilog/group_bank_exec.sv
verilog/group_resp_route.sv
verilog/group_interco.sv
testbench/group_interco_properties.sv
testbench/group_interco_tb.sv

// ==== testbench/group_interco_properties.sv ====
`timescale 1ns/1ps
`include "group_defs.svh"

module group_interco_properties
  import group_pkg::*;
(
  input logic                              clk_i,
  input logic                              rst_i,
  input logic       [`GROUP_NUM_PORTS-1:0] req_valid_i,
  input logic       [`GROUP_NUM_PORTS-1:0] req_ready_o,
  input tcdm_req_t  [`GROUP_NUM_PORTS-1:0] req_i,
  input logic       [`GROUP_NUM_PORTS-1:0] resp_valid_o,
  input logic       [`GROUP_NUM_PORTS-1:0] resp_ready_i,
  input tcdm_resp_t [`GROUP_NUM_PORTS-1:0] resp_o
);

  int unsigned fail_cnt = 0;

  for (genvar p = 0; p < `GROUP_NUM_PORTS; p++) begin : g_port
    // Stalled request keeps valid and payload
    req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      req_valid_i[p] && !req_ready_o[p] |=> req_valid_i[p] && $stable(req_i[p]))
      else begin
        $error("request on port %0d dropped or changed while stalled", p);
        fail_cnt++;
      end

    resp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      resp_valid_o[p] && !resp_ready_i[p] |=> resp_valid_o[p] && $stable(resp_o[p]))
      else begin
        $error("response on port %0d dropped or changed while stalled", p);
        fail_cnt++;
      end
  end

  resp_idle_in_reset: assert property (@(posedge clk_i) rst_i |=> resp_valid_o == '0)
    else begin
      $error("response valid raised during reset");
      fail_cnt++;
    end

endmodule

// ==== testbench/group_interco_tb.sv ====
`timescale 1ns/1ps
`include "group_defs.svh"

module group_interco_tb
  import group_pkg::*;
();

  localparam int NP      = `GROUP_NUM_PORTS;
  localparam int TIMEOUT = 40;

  logic                clk;
  logic                rst;
  logic       [NP-1:0] req_valid;
  logic       [NP-1:0] req_ready;
  tcdm_req_t  [NP-1:0] req;
  logic       [NP-1:0] resp_valid;
  logic       [NP-1:0] resp_ready;
  tcdm_resp_t [NP-1:0] resp;

  // Reference memory indexed by word address
  data_t  model [1 << `GROUP_ADDR_W];
  data_t  exp_q [NP][$];
  int     resp_cnt [NP];
  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  integer seed;

  group_interco dut0 (
    .clk_i        (clk       ),
    .rst_i        (rst       ),
    .req_valid_i  (req_valid ),
    .req_ready_o  (req_ready ),
    .req_i        (req       ),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_o       (resp      )
  );

  bind group_interco group_interco_properties u_props (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Every response transfer seen on each port
  always @(posedge clk) begin
    for (int p = 0; p < NP; p++) begin
      if (!rst && resp_valid[p] && resp_ready[p]) begin
        resp_cnt[p]++;
      end
    end
  end

  function automatic data_t merge_bytes(data_t old, data_t wdata, strb_t be);
    data_t res;
    res = old;
    for (int j = 0; j < `GROUP_DATA_W/8; j++) begin
      if (be[j]) begin
        res[8*j +: 8] = wdata[8*j +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_val(input string name, input data_t got, input data_t exp);
    check_cnt++;
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_done(input bit ok, input string what);
    check_cnt++;
    assert (ok) else begin
      $display("gave up after %0d cycles waiting for %s", TIMEOUT, what);
      err_cnt++;
    end
  endtask

  // Tasks below start and end on a falling edge; ready and valid are sampled 5 ns later
  task automatic send_req(input int p, input int addr, input logic wen, input data_t wdata,
                          input strb_t be);
    bit done;
    done         = 1'b0;
    req[p]       = '{tgt_addr: tgt_addr_t'(addr), wen: wen, wdata: wdata, be: be};
    req_valid[p] = 1'b1;
    for (int t = 0; t < TIMEOUT && !done; t++) begin
      #5;
      done = req_ready[p];
      @(negedge clk);
    end
    req_valid[p] = 1'b0;
    check_done(done, $sformatf("request acceptance on port %0d", p));
    if (done && wen) begin
      model[addr] = merge_bytes(model[addr], wdata, be);
      exp_q[p].push_back('0);
    end else if (done) begin
      exp_q[p].push_back(model[addr]);
    end
  endtask

  task automatic recv_resp(input int p);
    bit got;
    got = 1'b0;
    for (int t = 0; t < TIMEOUT && !got; t++) begin
      #5;
      if (resp_valid[p] && resp_ready[p]) begin
        got = 1'b1;
        check_val($sformatf("resp_o[%0d].rdata", p), resp[p].rdata, exp_q[p].pop_front());
      end
      @(negedge clk);
    end
    check_done(got, $sformatf("a response on port %0d", p));
  endtask

  task automatic xfer(input int p, input int addr, input logic wen, input data_t wdata,
                      input strb_t be);
    send_req(p, addr, wen, wdata, be);
    recv_resp(p);
  endtask

  task automatic end_test(input string name, input int e0);
    test_cnt++;
    if (err_cnt == e0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - e0);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = err_cnt;
    #5;
    check_val("resp_valid_o", data_t'(resp_valid), '0);
    check_val("req_ready_o", data_t'(req_ready), data_t'({NP{1'b1}}));
    @(negedge clk);
    end_test("reset state", e0);
  endtask

  task automatic test_write_read();
    int e0;
    e0 = err_cnt;
    xfer(0, 13, 1'b1, $random(seed), 4'hf);
    xfer(0, 13, 1'b0, '0, '0);
    end_test("write then read", e0);
  endtask

  task automatic test_byte_enables();
    int e0;
    e0 = err_cnt;
    for (int i = 0; i < 6; i++) begin
      xfer(1, 13, 1'b1, $random(seed), strb_t'($random(seed)));
      xfer(1, 13, 1'b0, '0, '0);
    end
    end_test("byte enables", e0);
  endtask

  task automatic test_shared_banks();
    int e0;
    e0 = err_cnt;
    // Row 5 in each of the four banks
    for (int b = 0; b < NP; b++) begin
      xfer(0, 20 + b, 1'b1, $random(seed), 4'hf);
    end
    for (int b = 0; b < NP; b++) begin
      xfer(3, 20 + b, 1'b0, '0, '0);
    end
    end_test("shared banks", e0);
  endtask

  task automatic test_conflict();
    int e0;
    int base [NP];
    e0 = err_cnt;
    // Bank 2, rows 1, 5, 9 and 13
    for (int r = 0; r < NP; r++) begin
      xfer(0, 16 * r + 6, 1'b1, $random(seed), 4'hf);
    end
    for (int p = 0; p < NP; p++) begin
      base[p] = resp_cnt[p];
    end
    fork
      xfer(0, 6, 1'b0, '0, '0);
      xfer(1, 22, 1'b0, '0, '0);
      xfer(2, 38, 1'b0, '0, '0);
      xfer(3, 54, 1'b0, '0, '0);
    join
    #5;
    check_val("resp_valid_o", data_t'(resp_valid), '0);
    for (int p = 0; p < NP; p++) begin
      check_val($sformatf("resp_valid_o[%0d] transfers", p), data_t'(resp_cnt[p] - base[p]),
                32'h1);
    end
    @(negedge clk);
    end_test("bank conflict", e0);
  endtask

  task automatic test_back_pressure();
    int    e0;
    bit    stalled;
    e0 = err_cnt;
    for (int r = 0; r < 3; r++) begin
      xfer(0, 16 * r + 10, 1'b1, $random(seed), 4'hf);
    end
    resp_ready[1] = 1'b0;
    send_req(1, 10, 1'b0, '0, '0);
    send_req(1, 26, 1'b0, '0, '0);
    stalled = 1'b0;
    for (int t = 0; t < TIMEOUT && !stalled; t++) begin
      #5;
      stalled = !req_ready[1] && resp_valid[1];
      @(negedge clk);
    end
    check_done(stalled, "port 1 to stall with a response held");
    // Port 2 keeps going on bank 1
    for (int i = 0; i < 3; i++) begin
      xfer(2, 4 * i + 1, 1'b1, $random(seed), 4'hf);
      check_val("resp_valid_o[1]", data_t'(resp_valid[1]), 32'h1);
      check_val("resp_o[1].rdata", resp[1].rdata, exp_q[1][0]);
    end
    fork
      send_req(1, 42, 1'b0, '0, '0);
      begin
        resp_ready[1] = 1'b1;
        repeat (3) recv_resp(1);
      end
    join
    end_test("back-pressure", e0);
  endtask

  initial begin
    seed       = 32'hd1e99bb4;
    err_cnt    = 0;
    check_cnt  = 0;
    test_cnt   = 0;
    rst        = 1'b1;
    req_valid  = '0;
    req        = '0;
    resp_ready = '1;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_write_read();
    test_byte_enables();
    test_shared_banks();
    test_conflict();
    test_back_pressure();

    err_cnt += int'(dut0.u_props.fail_cnt);
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/group_bank_exec.sv ====
`timescale 1ns/1ps
`include "group_defs.svh"

module group_bank_exec
  import group_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic       [`GROUP_NUM_PORTS-1:0]  pending_i,
  input  bank_req_t  [`GROUP_NUM_PORTS-1:0]  bank_req_i,
  input  logic       [`GROUP_NUM_PORTS-1:0]  accept_i,
  output logic       [`GROUP_NUM_PORTS-1:0]  grant_o,
  output bank_resp_t [`GROUP_NUM_PORTS-1:0]  bank_resp_o
);

  // Eligibility, indexed [bank][initiator]
  logic [`GROUP_NUM_PORTS-1:0][`GROUP_NUM_PORTS-1:0] elig;

  logic      [`GROUP_NUM_PORTS-1:0] bank_gnt;
  ini_id_t   [`GROUP_NUM_PORTS-1:0] win;
  bank_req_t [`GROUP_NUM_PORTS-1:0] win_req;
  ini_id_t   [`GROUP_NUM_PORTS-1:0] rr_q;

  logic    [`GROUP_NUM_PORTS-1:0] resp_valid_q;
  ini_id_t [`GROUP_NUM_PORTS-1:0] resp_ini_q;
  data_t   [`GROUP_NUM_PORTS-1:0] resp_rdata_q;

  data_t mem [`GROUP_NUM_PORTS][`GROUP_NUM_ROWS];

  always_comb begin
    for (int b = 0; b < `GROUP_NUM_PORTS; b++) begin
      for (int i = 0; i < `GROUP_NUM_PORTS; i++) begin
        elig[b][i] = pending_i[i] & accept_i[i] & (bank_req_i[i].bank == bank_sel_t'(b));
      end
    end
  end

  // Round-robin search starting at each bank's pointer
  always_comb begin
    ini_id_t idx;
    for (int b = 0; b < `GROUP_NUM_PORTS; b++) begin
      bank_gnt[b] = 1'b0;
      win[b]      = rr_q[b];
      for (int k = 0; k < `GROUP_NUM_PORTS; k++) begin
        idx = ini_id_t'((int'(rr_q[b]) + k) % `GROUP_NUM_PORTS);
        if (!bank_gnt[b] && elig[b][idx]) begin
          bank_gnt[b] = 1'b1;
          win[b]      = idx;
        end
      end
      win_req[b] = bank_req_i[win[b]];
    end
  end

  // Each initiator targets one bank, so at most one bank grants it
  always_comb begin
    grant_o = '0;
    for (int b = 0; b < `GROUP_NUM_PORTS; b++) begin
      if (bank_gnt[b]) begin
        grant_o[win[b]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q         <= '0;
      resp_valid_q <= '0;
    end else begin
      resp_valid_q <= bank_gnt;
      for (int b = 0; b < `GROUP_NUM_PORTS; b++) begin
        if (bank_gnt[b]) begin
          rr_q[b] <= ini_id_t'((int'(win[b]) + 1) % `GROUP_NUM_PORTS);
        end
      end
    end
  end

  // Bank access, byte-wise writes and registered reads
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `GROUP_NUM_PORTS; b++) begin
      if (bank_gnt[b]) begin
        resp_ini_q[b] <= win[b];
        if (win_req[b].wen) begin
          resp_rdata_q[b] <= '0;
          for (int j = 0; j < `GROUP_DATA_W/8; j++) begin
            if (win_req[b].be[j]) begin
              mem[b][win_req[b].row][8*j +: 8] <= win_req[b].wdata[8*j +: 8];
            end
          end
        end else begin
          resp_rdata_q[b] <= mem[b][win_req[b].row];
        end
      end
    end
  end

  always_comb begin
    for (int b = 0; b < `GROUP_NUM_PORTS; b++) begin
      bank_resp_o[b].valid = resp_valid_q[b];
      bank_resp_o[b].ini   = resp_ini_q[b];
      bank_resp_o[b].rdata = resp_rdata_q[b];
    end
  end

endmodule

// ==== verilog/group_defs.svh ====
`ifndef GROUP_DEFS_SVH
`define GROUP_DEFS_SVH

// Initiators and banks, one bank per initiator
`define GROUP_NUM_PORTS 4

// Words per bank
`define GROUP_NUM_ROWS 16

`define GROUP_DATA_W 32

// Low bits pick the bank, high bits the row
`define GROUP_ADDR_W 6

`endif

// ==== verilog/group_interco.sv ====
`timescale 1ns/1ps
`include "group_defs.svh"

module group_interco
  import group_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic       [`GROUP_NUM_PORTS-1:0]  req_valid_i,
  output logic       [`GROUP_NUM_PORTS-1:0]  req_ready_o,
  input  tcdm_req_t  [`GROUP_NUM_PORTS-1:0]  req_i,
  output logic       [`GROUP_NUM_PORTS-1:0]  resp_valid_o,
  input  logic       [`GROUP_NUM_PORTS-1:0]  resp_ready_i,
  output tcdm_resp_t [`GROUP_NUM_PORTS-1:0]  resp_o
);

  logic       [`GROUP_NUM_PORTS-1:0] pending;
  bank_req_t  [`GROUP_NUM_PORTS-1:0] bank_req;
  logic       [`GROUP_NUM_PORTS-1:0] grant;
  logic       [`GROUP_NUM_PORTS-1:0] accept;
  bank_resp_t [`GROUP_NUM_PORTS-1:0] bank_resp;

  // Request path
  group_req_decode u_decode (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .req_valid_i (req_valid_i),
    .req_i       (req_i      ),
    .req_ready_o (req_ready_o),
    .grant_i     (grant      ),
    .pending_o   (pending    ),
    .bank_req_o  (bank_req   )
  );

  group_bank_exec u_exec (
    .clk_i       (clk_i    ),
    .rst_i       (rst_i    ),
    .pending_i   (pending  ),
    .bank_req_i  (bank_req ),
    .accept_i    (accept   ),
    .grant_o     (grant    ),
    .bank_resp_o (bank_resp)
  );

  // Response path
  group_resp_route u_route (
    .clk_i        (clk_i       ),
    .rst_i        (rst_i       ),
    .bank_resp_i  (bank_resp   ),
    .resp_ready_i (resp_ready_i),
    .accept_o     (accept      ),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o      )
  );

endmodule

// ==== verilog/group_pkg.sv ====
`include "group_defs.svh"

package group_pkg;

  typedef logic [$clog2(`GROUP_NUM_PORTS)-1:0] ini_id_t;
  typedef logic [$clog2(`GROUP_NUM_PORTS)-1:0] bank_sel_t;
  typedef logic [$clog2(`GROUP_NUM_ROWS)-1:0]  row_t;
  typedef logic [`GROUP_ADDR_W-1:0]            tgt_addr_t;
  typedef logic [`GROUP_DATA_W-1:0]            data_t;
  typedef logic [`GROUP_DATA_W/8-1:0]          strb_t;

  // Request as issued by an initiator
  typedef struct packed {
    tgt_addr_t tgt_addr;
    logic      wen;
    data_t     wdata;
    strb_t     be;
  } tcdm_req_t;

  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

  // Request after address split
  typedef struct packed {
    bank_sel_t bank;
    row_t      row;
    logic      wen;
    data_t     wdata;
    strb_t     be;
  } bank_req_t;

  // One bank result, tagged with its initiator
  typedef struct packed {
    logic    valid;
    ini_id_t ini;
    data_t   rdata;
  } bank_resp_t;

endpackage

// ==== verilog/group_req_decode.sv ====
`timescale 1ns/1ps
`include "group_defs.svh"

module group_req_decode
  import group_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic      [`GROUP_NUM_PORTS-1:0]  req_valid_i,
  input  tcdm_req_t [`GROUP_NUM_PORTS-1:0]  req_i,
  output logic      [`GROUP_NUM_PORTS-1:0]  req_ready_o,
  input  logic      [`GROUP_NUM_PORTS-1:0]  grant_i,
  output logic      [`GROUP_NUM_PORTS-1:0]  pending_o,
  output bank_req_t [`GROUP_NUM_PORTS-1:0]  bank_req_o
);

  logic      [`GROUP_NUM_PORTS-1:0] slot_valid_q;
  logic      [`GROUP_NUM_PORTS-1:0] load;
  bank_req_t [`GROUP_NUM_PORTS-1:0] slot_q;
  bank_req_t [`GROUP_NUM_PORTS-1:0] req_dec;

  // Slot frees up in the same cycle it is granted
  assign req_ready_o = ~slot_valid_q | grant_i;
  assign load        = req_valid_i & req_ready_o;

  always_comb begin
    for (int p = 0; p < `GROUP_NUM_PORTS; p++) begin
      req_dec[p].bank  = req_i[p].tgt_addr[$bits(bank_sel_t)-1:0];
      req_dec[p].row   = req_i[p].tgt_addr[`GROUP_ADDR_W-1 -: $bits(row_t)];
      req_dec[p].wen   = req_i[p].wen;
      req_dec[p].wdata = req_i[p].wdata;
      req_dec[p].be    = req_i[p].be;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      slot_valid_q <= '0;
    end else begin
      slot_valid_q <= load | (slot_valid_q & ~grant_i);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `GROUP_NUM_PORTS; p++) begin
      if (load[p]) begin
        slot_q[p] <= req_dec[p];
      end
    end
  end

  assign pending_o  = slot_valid_q;
  assign bank_req_o = slot_q;

endmodule

// ==== verilog/group_resp_route.sv ====
`timescale 1ns/1ps
`include "group_defs.svh"

module group_resp_route
  import group_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  bank_resp_t [`GROUP_NUM_PORTS-1:0]  bank_resp_i,
  input  logic       [`GROUP_NUM_PORTS-1:0]  resp_ready_i,
  output logic       [`GROUP_NUM_PORTS-1:0]  accept_o,
  output logic       [`GROUP_NUM_PORTS-1:0]  resp_valid_o,
  output tcdm_resp_t [`GROUP_NUM_PORTS-1:0]  resp_o
);

  logic  [`GROUP_NUM_PORTS-1:0] hit;
  data_t [`GROUP_NUM_PORTS-1:0] hit_data;
  logic  [`GROUP_NUM_PORTS-1:0] resp_valid_q;
  data_t [`GROUP_NUM_PORTS-1:0] resp_data_q;

  // Steer by initiator tag, at most one bank per initiator
  always_comb begin
    for (int p = 0; p < `GROUP_NUM_PORTS; p++) begin
      hit[p]      = 1'b0;
      hit_data[p] = '0;
      for (int b = 0; b < `GROUP_NUM_PORTS; b++) begin
        if (bank_resp_i[b].valid && bank_resp_i[b].ini == ini_id_t'(p)) begin
          hit[p]      = 1'b1;
          hit_data[p] = bank_resp_i[b].rdata;
        end
      end
    end
  end

  // A bank response always finds its register free when it lands
  assign accept_o = (~resp_valid_q | resp_ready_i) & ~hit;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= '0;
    end else begin
      resp_valid_q <= hit | (resp_valid_q & ~resp_ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int p = 0; p < `GROUP_NUM_PORTS; p++) begin
      if (hit[p]) begin
        resp_data_q[p] <= hit_data[p];
      end
    end
  end

  assign resp_valid_o = resp_valid_q;

  always_comb begin
    for (int p = 0; p < `GROUP_NUM_PORTS; p++) begin
      resp_o[p].rdata = resp_data_q[p];
    end
  end

endmodule
